// File: Bender.yml
package:
  name: trig_gen

sources:
  - files:
      - rtl/trig_pkg.sv
      - rtl/trig_mask_reg.sv
      - rtl/trig_beam_detect.sv
      - rtl/trig_word_gen.sv
      - rtl/trig_out_fifo.sv
      - rtl/trig_gen_top.sv
  - target: test
    files:
      - testbench/trig_gen_properties.sv
      - testbench/trig_gen_checker.sv
      - testbench/tb_trig_gen.sv

// File: rtl/trig_beam_detect.sv
`timescale 1ns/1ps
`default_nettype none

module trig_beam_detect import trig_pkg::*; (
    input  wire logic      ifclk,
    input  wire logic      runrst_i,
    input  wire logic      gen_rst_i,
    input  wire beam_vec_t trig_i,
    input  wire beam_vec_t mask_active_i,
    output logic           hit_o
);

    // soft reset, one register stage
    logic gen_rst_q;
    // beams that survived the mask, one cycle after sampling
    beam_vec_t masked_q;
    // or of the surviving beams
    logic raw_trig;
    // blocks new hits while set
    logic holdoff;
    // hit delayed toward the end of the holdoff window
    logic [HOLDOFF_DLY-1:0] hit_dly;
    logic holdoff_done;

    // set mask bit kills its beam
    assign raw_trig = |masked_q;
    // last tap of the delay line
    assign holdoff_done = hit_dly[HOLDOFF_DLY-1];

    always_ff @(posedge ifclk) begin
        if (runrst_i) begin
            gen_rst_q <= 1'b0;
        end else begin
            gen_rst_q <= gen_rst_i;
        end
    end

    always_ff @(posedge ifclk) begin
        if (runrst_i || gen_rst_q) begin
            masked_q <= '0;
            hit_o    <= 1'b0;
            holdoff  <= 1'b0;
            hit_dly  <= '0;
        end else begin
            masked_q <= trig_i & ~mask_active_i;

            // accept only when the window is open
            hit_o <= raw_trig && !holdoff;

            // end of window takes priority over a new raw trigger
            if (holdoff_done) begin
                holdoff <= 1'b0;
            end else if (raw_trig) begin
                holdoff <= 1'b1;
            end

            // hit at c comes out at c+6 so holdoff is clear again at c+7
            hit_dly <= {hit_dly[HOLDOFF_DLY-2:0], hit_o};
        end
    end

endmodule

`default_nettype wire

// File: rtl/trig_gen_top.sv
`timescale 1ns/1ps
`default_nettype none

module trig_gen_top import trig_pkg::*; (
    input  wire logic              ifclk,
    input  wire logic              runrst_i,
    input  wire logic              runstop_i,
    input  wire logic              gen_rst_i,
    input  wire beam_vec_t         trig_i,
    input  wire logic [NBEAMS-1:0] mask_i,
    input  wire logic [1:0]        mask_wr_i,
    input  wire logic              mask_update_i,
    input  wire logic              trig_tready_i,
    output logic                   trig_tvalid_o,
    output trig_word_t             trig_tdata_o,
    output logic                   overflow_o
);

    beam_vec_t  mask_active;
    logic       hit;
    logic       word_wr;
    trig_word_t word_data;

    // staged and active beam masks
    trig_mask_reg u_mask (
        .ifclk         (ifclk),
        .runrst_i      (runrst_i),
        .mask_i        (mask_i),
        .mask_wr_i     (mask_wr_i),
        .mask_update_i (mask_update_i),
        .mask_active_o (mask_active)
    );

    // masked or-reduction plus holdoff
    trig_beam_detect u_detect (
        .ifclk         (ifclk),
        .runrst_i      (runrst_i),
        .gen_rst_i     (gen_rst_i),
        .trig_i        (trig_i),
        .mask_active_i (mask_active),
        .hit_o         (hit)
    );

    // address stamping
    trig_word_gen u_word (
        .ifclk       (ifclk),
        .runrst_i    (runrst_i),
        .runstop_i   (runstop_i),
        .hit_i       (hit),
        .word_wr_o   (word_wr),
        .word_data_o (word_data)
    );

    // output queue onto the stream
    trig_out_fifo #(
        .DEPTH (FIFO_DEPTH)
    ) u_fifo (
        .ifclk      (ifclk),
        .runrst_i   (runrst_i),
        .gen_rst_i  (gen_rst_i),
        .wr_i       (word_wr),
        .data_i     (word_data),
        .tready_i   (trig_tready_i),
        .tvalid_o   (trig_tvalid_o),
        .tdata_o    (trig_tdata_o),
        .overflow_o (overflow_o)
    );

endmodule

`default_nettype wire

// File: rtl/trig_mask_reg.sv
`timescale 1ns/1ps
`default_nettype none

module trig_mask_reg import trig_pkg::*; (
    input  wire logic              ifclk,
    input  wire logic              runrst_i,
    input  wire logic [NBEAMS-1:0] mask_i,
    input  wire logic [1:0]        mask_wr_i,
    input  wire logic              mask_update_i,
    output beam_vec_t              mask_active_o
);

    // staging halves, written one at a time
    logic [MASK_LO_W-1:0] stage_lo;
    logic [MASK_HI_W-1:0] stage_hi;

    always_ff @(posedge ifclk) begin
        if (runrst_i) begin
            // everything masked until the host says otherwise
            stage_lo <= '1;
            stage_hi <= '1;
        end else begin
            // low half comes from the bottom 30 bits
            if (mask_wr_i[0]) begin
                stage_lo <= mask_i[MASK_LO_W-1:0];
            end
            // high half is the top 18 bits of the same bus
            if (mask_wr_i[1]) begin
                stage_hi <= mask_i[NBEAMS-1:MASK_LO_W];
            end
        end
    end

    // whole mask moves at once so detection never sees half of an update
    always_ff @(posedge ifclk) begin
        if (runrst_i) begin
            mask_active_o <= '1;
        end else if (mask_update_i) begin
            mask_active_o <= {stage_hi, stage_lo};
        end
    end

endmodule

`default_nettype wire

// File: rtl/trig_out_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module trig_out_fifo import trig_pkg::*; #(
    parameter int DEPTH = FIFO_DEPTH
) (
    input  wire logic       ifclk,
    input  wire logic       runrst_i,
    input  wire logic       gen_rst_i,
    input  wire logic       wr_i,
    input  wire trig_word_t data_i,
    input  wire logic       tready_i,
    output logic            tvalid_o,
    output trig_word_t      tdata_o,
    output logic            overflow_o
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    trig_word_t mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic gen_rst_q;
    logic full;
    logic wr_ok;
    logic rd_ok;

    assign full  = (count == CNT_W'(DEPTH));
    // full means the word is lost, even if a read happens the same cycle
    assign wr_ok = wr_i && !full;
    assign rd_ok = tvalid_o && tready_i;

    // show-ahead: head word sits on the output whenever anything is stored
    assign tvalid_o = (count != '0);
    assign tdata_o  = mem[rd_ptr];

    always_ff @(posedge ifclk) begin
        if (runrst_i) begin
            gen_rst_q <= 1'b0;
        end else begin
            gen_rst_q <= gen_rst_i;
        end
    end

    always_ff @(posedge ifclk) begin
        if (wr_ok) begin
            mem[wr_ptr] <= data_i;
        end
    end

    always_ff @(posedge ifclk) begin
        if (runrst_i || gen_rst_q) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            overflow_o <= 1'b0;
        end else begin
            // pointers wrap explicitly so any depth works
            if (wr_ok) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + PTR_W'(1);
            end
            if (rd_ok) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + PTR_W'(1);
            end
            case ({wr_ok, rd_ok})
                2'b10:   count <= count + CNT_W'(1);
                2'b01:   count <= count - CNT_W'(1);
                default: count <= count;
            endcase
            // sticky until a soft or run reset
            if (wr_i && full) begin
                overflow_o <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/trig_pkg.sv
`default_nettype none

package trig_pkg;

    // beam count is fixed, the mask split below only adds up for 48
    localparam int NBEAMS = 48;
    localparam int MASK_LO_W = 30;
    localparam int MASK_HI_W = 18;

    // at most one accepted trigger per this many clocks
    localparam int HOLDOFF_CYCLES = 8;
    // hit is fed back through this many delay stages to end the holdoff
    localparam int HOLDOFF_DLY = HOLDOFF_CYCLES - 2;

    localparam int ADDR_W = 12;
    localparam int WORD_W = 32;
    localparam int FIFO_DEPTH = 16;

    // header bits at the top of every trigger word
    localparam logic [1:0] WORD_HDR = 2'b10;
    // zero field under the address
    localparam int WORD_PAD_W = WORD_W - 2 - ADDR_W;

    // per-beam trigger or mask bits
    typedef logic [NBEAMS-1:0] beam_vec_t;
    typedef logic [ADDR_W-1:0] trig_addr_t;
    typedef logic [WORD_W-1:0] trig_word_t;

    typedef enum logic {
        STOPPED,
        RUNNING
    } run_state_t;

endpackage

`default_nettype wire

// File: rtl/trig_word_gen.sv
`timescale 1ns/1ps
`default_nettype none

module trig_word_gen import trig_pkg::*; (
    input  wire logic ifclk,
    input  wire logic runrst_i,
    input  wire logic runstop_i,
    input  wire logic hit_i,
    output logic      word_wr_o,
    output trig_word_t word_data_o
);

    run_state_t run_state;
    // free-running run address
    trig_addr_t cur_addr;
    // address latched on the hit
    trig_addr_t cap_addr;

    // runrst starts a run, runstop ends it
    always_ff @(posedge ifclk) begin
        if (runrst_i) begin
            run_state <= RUNNING;
        end else if (runstop_i) begin
            run_state <= STOPPED;
        end
    end

    // 1 in the first cycle after reset, then counts while running
    always_ff @(posedge ifclk) begin
        if (runrst_i || run_state == STOPPED) begin
            cur_addr <= trig_addr_t'(1);
        end else begin
            cur_addr <= cur_addr + trig_addr_t'(1);
        end
    end

    always_ff @(posedge ifclk) begin
        if (hit_i) begin
            cap_addr <= cur_addr;
        end
    end

    // write strobe trails the hit by one cycle, lined up with cap_addr
    always_ff @(posedge ifclk) begin
        if (runrst_i) begin
            word_wr_o <= 1'b0;
        end else begin
            word_wr_o <= hit_i;
        end
    end

    // header, address, then zeros
    assign word_data_o = {WORD_HDR, cap_addr, {WORD_PAD_W{1'b0}}};

endmodule

`default_nettype wire

// File: testbench/tb_trig_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_trig_gen import trig_pkg::*; ();

    localparam int CLK_PERIOD = 4;
    // all stimulus phases below added up
    localparam int STIM_CYCLES = 1040;
    localparam int DRAIN_MARGIN = 200;
    // one enabled beam in each mask half
    localparam int BEAM_LO = 3;
    localparam int BEAM_HI = 40;

    logic        ifclk;
    logic        runrst;
    logic        runstop;
    logic        gen_rst;
    beam_vec_t   trig;
    beam_vec_t   mask;
    logic [1:0]  mask_wr;
    logic        mask_update;
    logic        trig_tready;
    logic        trig_tvalid;
    trig_word_t  trig_tdata;
    logic        overflow;
    int          mismatch_cnt;
    int          missing_cnt;
    int          pending;
    int          assert_fails;
    integer      seed;
    beam_vec_t   test_mask;
    int          i;

    trig_gen_top trig_gen_top_i (
        .ifclk         (ifclk),
        .runrst_i      (runrst),
        .runstop_i     (runstop),
        .gen_rst_i     (gen_rst),
        .trig_i        (trig),
        .mask_i        (mask),
        .mask_wr_i     (mask_wr),
        .mask_update_i (mask_update),
        .trig_tready_i (trig_tready),
        .trig_tvalid_o (trig_tvalid),
        .trig_tdata_o  (trig_tdata),
        .overflow_o    (overflow)
    );

    trig_gen_checker u_checker (
        .ifclk          (ifclk),
        .runrst_i       (runrst),
        .runstop_i      (runstop),
        .gen_rst_i      (gen_rst),
        .trig_i         (trig),
        .mask_i         (mask),
        .mask_wr_i      (mask_wr),
        .mask_update_i  (mask_update),
        .trig_tready_i  (trig_tready),
        .trig_tvalid_i  (trig_tvalid),
        .trig_tdata_i   (trig_tdata),
        .overflow_i     (overflow),
        .mismatch_cnt_o (mismatch_cnt),
        .missing_cnt_o  (missing_cnt),
        .pending_o      (pending)
    );

    initial begin
        ifclk = 1'b0;
        forever #(CLK_PERIOD / 2) ifclk = ~ifclk;
    end

    // advance n rising edges, then settle just after the last one
    task automatic next_cycle(input int n);
        repeat (n) @(posedge ifclk);
        #1;
    endtask

    // 48 random beam bits from two draws
    function automatic beam_vec_t random_beams();
        beam_vec_t v;
        v[31:0] = $random(seed);
        v[47:32] = 16'($random(seed));
        return v;
    endfunction

    initial begin
        #((STIM_CYCLES + DRAIN_MARGIN) * CLK_PERIOD);
        $display("timeout: run did not finish within %0d cycles", STIM_CYCLES + DRAIN_MARGIN);
        $display("tests failed");
        $finish;
    end

    initial begin
        seed = 16;
        runrst = 1'b1;
        runstop = 1'b0;
        gen_rst = 1'b0;
        trig = '0;
        mask = '1;
        mask_wr = 2'b00;
        mask_update = 1'b0;
        trig_tready = 1'b1;
        test_mask = ~((beam_vec_t'(1) << BEAM_LO) | (beam_vec_t'(1) << BEAM_HI));
        next_cycle(5);
        runrst = 1'b0;

        // every beam masked, random activity stays silent
        for (i = 0; i < 100; i++) begin
            trig = random_beams();
            next_cycle(1);
        end

        // stage both halves, active mask stays all ones until update
        mask = test_mask;
        mask_wr = 2'b01;
        next_cycle(1);
        mask_wr = 2'b10;
        next_cycle(1);
        mask_wr = 2'b00;
        for (i = 0; i < 30; i++) begin
            trig = random_beams();
            next_cycle(1);
        end
        trig = '0;
        mask_update = 1'b1;
        next_cycle(1);
        mask_update = 1'b0;

        // noise on masked beams, isolated pulses on the enabled ones
        for (i = 0; i < 120; i++) begin
            trig = random_beams() & test_mask;
            if (i % 20 == 0) begin
                trig[BEAM_LO] = 1'b1;
            end
            if (i % 20 == 10) begin
                trig[BEAM_HI] = 1'b1;
            end
            next_cycle(1);
        end

        // dense bursts against holdoff with random back-pressure
        for (i = 0; i < 150; i++) begin
            trig = random_beams();
            trig_tready = 1'($random(seed));
            next_cycle(1);
        end
        trig = '0;
        trig_tready = 1'b1;
        next_cycle(20);

        // ready held low well past the FIFO depth
        trig_tready = 1'b0;
        trig = beam_vec_t'(1) << BEAM_LO;
        next_cycle(200);
        trig = '0;
        next_cycle(10);
        trig_tready = 1'b1;
        next_cycle(30);
        // partly refill, then soft reset empties it and clears overflow
        trig_tready = 1'b0;
        trig = beam_vec_t'(1) << BEAM_HI;
        next_cycle(30);
        trig = '0;
        next_cycle(12);
        gen_rst = 1'b1;
        next_cycle(1);
        gen_rst = 1'b0;
        next_cycle(5);
        trig_tready = 1'b1;
        next_cycle(20);

        // stopped run stamps address 1
        runstop = 1'b1;
        next_cycle(1);
        runstop = 1'b0;
        for (i = 0; i < 60; i++) begin
            trig = (i % 20 == 5) ? (beam_vec_t'(1) << BEAM_LO) : '0;
            next_cycle(1);
        end
        trig = '0;
        next_cycle(10);

        // overfill while stalled, then run reset drops the words and overflow
        trig_tready = 1'b0;
        trig = beam_vec_t'(1) << BEAM_HI;
        next_cycle(150);
        trig = '0;
        next_cycle(10);
        runrst = 1'b1;
        next_cycle(1);
        runrst = 1'b0;
        trig_tready = 1'b1;
        // run reset masked every beam again, reload the test mask
        mask_wr = 2'b11;
        next_cycle(1);
        mask_wr = 2'b00;
        mask_update = 1'b1;
        next_cycle(1);
        mask_update = 1'b0;
        // fresh run counts addresses from the reset again
        for (i = 0; i < 40; i++) begin
            trig = (i % 20 == 5) ? (beam_vec_t'(1) << BEAM_LO) : '0;
            next_cycle(1);
        end
        trig = '0;
        next_cycle(30);

        assert_fails = trig_gen_top_i.u_props.fail_cnt;
        if (pending != 0) begin
            $display("%0d expected words never came out of the stream", pending);
        end
        $display("errors: %0d mismatches, %0d missing or extra words, %0d assertion failures",
                 mismatch_cnt, missing_cnt + pending, assert_fails);
        if (mismatch_cnt == 0 && missing_cnt == 0 && pending == 0 && assert_fails == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: testbench/trig_gen_checker.sv
`timescale 1ns/1ps
`default_nettype none

module trig_gen_checker import trig_pkg::*; (
    input  wire logic              ifclk,
    input  wire logic              runrst_i,
    input  wire logic              runstop_i,
    input  wire logic              gen_rst_i,
    input  wire beam_vec_t         trig_i,
    input  wire logic [NBEAMS-1:0] mask_i,
    input  wire logic [1:0]        mask_wr_i,
    input  wire logic              mask_update_i,
    input  wire logic              trig_tready_i,
    input  wire logic              trig_tvalid_i,
    input  wire trig_word_t        trig_tdata_i,
    input  wire logic              overflow_i,
    output int                     mismatch_cnt_o,
    output int                     missing_cnt_o,
    output int                     pending_o
);

    // words the FIFO should hold, head first
    trig_word_t exp_q[$];
    beam_vec_t  stage;
    beam_vec_t  active;
    // some enabled beam was set one cycle back
    logic       raw;
    logic       hit;
    logic       wr;
    // soft reset after its register stage
    logic       grst_q;
    logic       overflow;
    // model only means something after the first run reset
    logic       armed;
    run_state_t run;
    trig_addr_t addr;
    trig_addr_t cap;
    longint     cyc;
    longint     last_hit;

    // header 10, address, 18 zero bits
    function automatic trig_word_t expected_word(input trig_addr_t a);
        return {2'b10, a, 18'h0};
    endfunction

    // a set mask bit disables its beam
    function automatic logic beams_fire(input beam_vec_t t, input beam_vec_t m);
        return |(t & ~m);
    endfunction

    // next hit may come 8 clocks after the previous accepted one
    function automatic logic holdoff_open(input longint now, input longint last);
        return (now - last) >= HOLDOFF_CYCLES;
    endfunction

    initial begin
        armed = 1'b0;
        cyc = 0;
        mismatch_cnt_o = 0;
        missing_cnt_o = 0;
        pending_o = 0;
    end

    always @(posedge ifclk) begin : model_step
        logic full;
        // compare what the DUT showed in the cycle that just ended
        if (armed) begin
            if (overflow_i !== overflow) begin
                $display("Mismatch overflow_o: got %h, expected %h at %0t",
                         overflow_i, overflow, $time);
                mismatch_cnt_o++;
            end
            if (trig_tvalid_i !== (exp_q.size() != 0)) begin
                if (exp_q.size() != 0) begin
                    $display("word %h was due on the stream but valid is low at %0t",
                             exp_q[0], $time);
                end else begin
                    $display("stream shows a word that no trigger accounts for at %0t", $time);
                end
                missing_cnt_o++;
            end else if (trig_tvalid_i && trig_tready_i && trig_tdata_i !== exp_q[0]) begin
                $display("Mismatch trig_tdata_o: got %h, expected %h at %0t",
                         trig_tdata_i, exp_q[0], $time);
                mismatch_cnt_o++;
            end
        end

        full = (exp_q.size() == FIFO_DEPTH);
        if (runrst_i) begin
            stage = '1;
            active = '1;
            raw = 1'b0;
            hit = 1'b0;
            wr = 1'b0;
            grst_q = 1'b0;
            overflow = 1'b0;
            run = RUNNING;
            addr = 1;
            last_hit = cyc - HOLDOFF_CYCLES;
            exp_q.delete();
            armed = 1'b1;
        end else begin
            // FIFO first, it takes the word stamped on the previous edge
            if (grst_q) begin
                exp_q.delete();
                overflow = 1'b0;
            end else begin
                if (exp_q.size() != 0 && trig_tready_i) begin
                    void'(exp_q.pop_front());
                end
                if (wr && full) begin
                    overflow = 1'b1;
                end else if (wr) begin
                    exp_q.push_back(expected_word(cap));
                end
            end
            // stamping, address runs only while the run is on
            wr = hit;
            if (hit) begin
                cap = addr;
            end
            addr = (run == STOPPED) ? trig_addr_t'(1) : addr + trig_addr_t'(1);
            if (runstop_i) begin
                run = STOPPED;
            end
            // detection against the mask that was active this cycle
            if (grst_q) begin
                raw = 1'b0;
                hit = 1'b0;
                last_hit = cyc - HOLDOFF_CYCLES;
            end else begin
                hit = raw && holdoff_open(cyc + 1, last_hit);
                if (hit) begin
                    last_hit = cyc + 1;
                end
                raw = beams_fire(trig_i, active);
            end
            grst_q = gen_rst_i;
            // update copies the old staging, writes land in staging only
            if (mask_update_i) begin
                active = stage;
            end
            if (mask_wr_i[0]) begin
                stage[29:0] = mask_i[29:0];
            end
            if (mask_wr_i[1]) begin
                stage[47:30] = mask_i[47:30];
            end
        end
        cyc++;
        pending_o = exp_q.size();
    end

endmodule

`default_nettype wire

// File: testbench/trig_gen_properties.sv
`timescale 1ns/1ps
`default_nettype none

module trig_gen_properties import trig_pkg::*; (
    input wire logic       ifclk,
    input wire logic       runrst_i,
    input wire logic       hit_i,
    input wire logic       tvalid_i,
    input wire logic       tready_i,
    input wire trig_word_t tdata_i
);

    // failed assertions so far
    int fail_cnt = 0;

    // a stalled word leaves only by handshake or when a soft reset empties the FIFO
    stall_hold: assert property (@(posedge ifclk) disable iff (runrst_i)
        tvalid_i && !tready_i |=> !tvalid_i || $stable(tdata_i))
        else begin
            fail_cnt++;
            $error("stream data changed while the word was stalled");
        end

    // holdoff keeps accepted hits at least 8 clocks apart
    hit_spacing: assert property (@(posedge ifclk) disable iff (runrst_i)
        hit_i |=> !hit_i [*(HOLDOFF_CYCLES-1)])
        else begin
            fail_cnt++;
            $error("hit pulsed again inside the holdoff window");
        end

    quiet_after_reset: assert property (@(posedge ifclk)
        runrst_i |=> !tvalid_i)
        else begin
            fail_cnt++;
            $error("stream valid was high right after run reset");
        end

endmodule

bind trig_gen_top trig_gen_properties u_props (
    .ifclk    (ifclk),
    .runrst_i (runrst_i),
    .hit_i    (hit),
    .tvalid_i (trig_tvalid_o),
    .tready_i (trig_tready_i),
    .tdata_i  (trig_tdata_o)
);

`default_nettype wire

// File: verilog.f
rtl/trig_pkg.sv
rtl/trig_mask_reg.sv
rtl/trig_beam_detect.sv
rtl/trig_word_gen.sv
rtl/trig_out_fifo.sv
rtl/trig_gen_top.sv
testbench/trig_gen_properties.sv
testbench/trig_gen_checker.sv
testbench/tb_trig_gen.sv
